// File: Makefile
# Verilator build and run for the memory pipeline slice

VERILATOR ?= verilator
TOP       ?= memPipeTb
FILELIST  ?= all.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing
SIMARGS   ?= +verilator+error+limit+1000
FAILTEXT  ?= STATUS: FAIL
PASSTEXT  ?= STATUS: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) $(SIMARGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAILTEXT)" $(LOG); then exit 1; fi
	@if ! grep -q "$(PASSTEXT)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: all.f
+incdir+rtl
rtl/memOpPkg.sv
rtl/recoveryPkg.sv
rtl/flushRangeCheck.sv
rtl/dataMemory.sv
rtl/ioRegisterFile.sv
rtl/memoryAccessStage.sv
rtl/memPipeTop.sv
verification/tbClock.sv
verification/memPipe_sva.sv
verification/memPipeTb.sv

// File: rtl/dataMemory.sv
/*
 * Data RAM
 * Word-addressed, one synchronous read port and one write port per lane.
 * Read registers keep their value while hold is high
 */
`include "memPipe_defines.svh"

module dataMemory (
    input  logic                                         clk,
    input  logic                                         hold,
    input  logic [`MEM_LANES-1:0][`MEM_INDEX_WIDTH-1:0]  readIndex,
    input  logic [`MEM_LANES-1:0]                        writeEnable,
    input  logic [`MEM_LANES-1:0][`MEM_INDEX_WIDTH-1:0]  writeIndex,
    input  logic [`MEM_LANES-1:0][`DATA_WIDTH-1:0]       writeData,
    output logic [`MEM_LANES-1:0][`DATA_WIDTH-1:0]       readData
);

    logic [`DATA_WIDTH-1:0] memArray [`MEM_WORDS];

    // Registered reads
    always_ff @(posedge clk) begin
        if (!hold) begin
            for (int i = 0; i < `MEM_LANES; i++) begin
                readData[i] <= memArray[readIndex[i]];
            end
        end
    end

    // Higher lane is written last and wins on a collision
    always_ff @(posedge clk) begin
        for (int i = 0; i < `MEM_LANES; i++) begin
            if (writeEnable[i]) begin
                memArray[writeIndex[i]] <= writeData[i];
            end
        end
    end

endmodule

// File: rtl/flushRangeCheck.sv
/*
 * Selective flush detector
 * Flags an op whose active-list pointer lies in [flushHead, flushTail)
 * during a flush, with wraparound, or any op when flushAll is set
 */
`include "memPipe_defines.svh"

module flushRangeCheck (
    input  recoveryPkg::recoveryPhase phase,
    input  logic                      flushAll,
    input  recoveryPkg::activeListPtr flushHead,
    input  recoveryPkg::activeListPtr flushTail,
    input  recoveryPkg::activeListPtr opPtr,
    output logic                      flushed
);

    logic inRange;

    always_comb begin
        if (flushHead <= flushTail) begin
            // Plain range that is empty when head equals tail
            inRange = (opPtr >= flushHead) && (opPtr < flushTail);
        end else begin
            // Range wraps past the last entry
            inRange = (opPtr >= flushHead) || (opPtr < flushTail);
        end
    end

    assign flushed = (phase == recoveryPkg::RP_FLUSH) && (flushAll || inRange);

endmodule

// File: rtl/ioRegisterFile.sv
/*
 * Memory-mapped IO registers
 * Eight words with a combinational read for the IO lane.
 * Register n resets to n * 0x11
 */
`include "memPipe_defines.svh"

module ioRegisterFile (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [`IO_INDEX_WIDTH-1:0]  readIndex,
    input  logic                        writeEnable,
    input  logic [`IO_INDEX_WIDTH-1:0]  writeIndex,
    input  logic [`DATA_WIDTH-1:0]      writeData,
    output logic [`DATA_WIDTH-1:0]      readData
);

    logic [`DATA_WIDTH-1:0] ioRegs [`IO_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `IO_REGS; i++) begin
                ioRegs[i] <= `DATA_WIDTH'(i * 32'h11);
            end
        end else if (writeEnable) begin
            ioRegs[writeIndex] <= writeData;
        end
    end

    assign readData = ioRegs[readIndex];

endmodule

// File: rtl/memOpPkg.sv
/*
 * Memory micro-op types
 * Operation kinds, memory map type and the operand word that
 * carries either an address or a raw CSR value
 */
`include "memPipe_defines.svh"

package memOpPkg;

    // What the memory access stage returns for the op
    typedef enum logic [1:0] {
        OP_LOAD  = 2'd0,
        OP_STORE = 2'd1,
        OP_CSR   = 2'd2,
        OP_ADDR  = 2'd3
    } opKind;

    // Decoded from the address region
    typedef enum logic {
        MMT_MEMORY = 1'b0,
        MMT_IO     = 1'b1
    } memMapType;

    typedef struct packed {
        logic [3:0]  region;
        logic [25:0] index;
        logic [1:0]  byteOffset;
    } memAddr;

    // Address for load, store and address ops; raw value for CSR ops
    typedef union packed {
        memAddr                  addr;
        logic [`DATA_WIDTH-1:0]  csrValue;
    } operandWord;

endpackage

// File: rtl/memPipeTop.sv
/*
 * Two-lane memory pipeline slice
 * Issue latch into the tag access stage, data RAM, IO registers,
 * memory access stage and writeback register
 */
`include "memPipe_defines.svh"

module memPipeTop (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic [`MEM_LANES-1:0]                        issueValid,
    input  memOpPkg::opKind [`MEM_LANES-1:0]             issueKind,
    input  memOpPkg::operandWord [`MEM_LANES-1:0]        issueOperand,
    input  logic [`MEM_LANES-1:0][`DATA_WIDTH-1:0]       issueStoreData,
    input  recoveryPkg::activeListPtr [`MEM_LANES-1:0]   issueAlPtr,
    input  logic [`MEM_LANES-1:0][`DST_WIDTH-1:0]        issueDst,
    input  recoveryPkg::recoveryPhase                    phase,
    input  logic                                         flushAll,
    input  recoveryPkg::activeListPtr                    flushHead,
    input  recoveryPkg::activeListPtr                    flushTail,
    input  logic                                         stall,
    input  logic                                         clear,
    output logic [`MEM_LANES-1:0]                        bypassValid,
    output logic [`MEM_LANES-1:0][`DATA_WIDTH-1:0]       bypassData,
    output logic [`MEM_LANES-1:0]                        wbValid,
    output logic [`MEM_LANES-1:0][`DATA_WIDTH-1:0]       wbData,
    output logic [`MEM_LANES-1:0][`DST_WIDTH-1:0]        wbDst,
    output recoveryPkg::activeListPtr [`MEM_LANES-1:0]   wbAlPtr
);

    memOpPkg::memMapType [`MEM_LANES-1:0]        issueMapType;

    logic [`MEM_LANES-1:0]                       tagValid;
    memOpPkg::opKind [`MEM_LANES-1:0]            tagKind;
    memOpPkg::operandWord [`MEM_LANES-1:0]       tagOperand;
    memOpPkg::memMapType [`MEM_LANES-1:0]        tagMapType;
    logic [`MEM_LANES-1:0][`DATA_WIDTH-1:0]      tagStoreData;
    recoveryPkg::activeListPtr [`MEM_LANES-1:0]  tagAlPtr;
    logic [`MEM_LANES-1:0][`DST_WIDTH-1:0]       tagDst;

    logic [`MEM_LANES-1:0][`MEM_INDEX_WIDTH-1:0] readIndex;
    logic [`MEM_LANES-1:0][`DATA_WIDTH-1:0]      memReadData;
    logic [`DATA_WIDTH-1:0]                      ioReadData;
    logic [`IO_INDEX_WIDTH-1:0]                  ioReadIndex;
    logic [`MEM_LANES-1:0]                       storeEnable;
    logic [`MEM_LANES-1:0][`MEM_INDEX_WIDTH-1:0] storeIndex;
    logic [`MEM_LANES-1:0][`DATA_WIDTH-1:0]      storeData;
    logic                                        ioWriteEnable;

    logic [`MEM_LANES-1:0]                       nextValid;
    logic [`MEM_LANES-1:0][`DATA_WIDTH-1:0]      nextData;
    logic [`MEM_LANES-1:0][`DST_WIDTH-1:0]       nextDst;
    recoveryPkg::activeListPtr [`MEM_LANES-1:0]  nextAlPtr;

    // Region decode for loads and stores
    always_comb begin
        for (int i = 0; i < `MEM_LANES; i++) begin
            if ((issueKind[i] == memOpPkg::OP_LOAD || issueKind[i] == memOpPkg::OP_STORE) &&
                issueOperand[i].addr.region == `IO_REGION) begin
                issueMapType[i] = memOpPkg::MMT_IO;
            end else begin
                issueMapType[i] = memOpPkg::MMT_MEMORY;
            end
            readIndex[i] = tagOperand[i].addr.index[`MEM_INDEX_WIDTH-1:0];
        end
    end

    // Tag access stage register
    always_ff @(posedge clk) begin
        if (reset) begin
            tagValid <= '0;
        end else if (!stall) begin
            tagValid <= issueValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            tagKind      <= issueKind;
            tagOperand   <= issueOperand;
            tagMapType   <= issueMapType;
            tagStoreData <= issueStoreData;
            tagAlPtr     <= issueAlPtr;
            tagDst       <= issueDst;
        end
    end

    dataMemory dataRam (
        .clk        (clk),
        .hold       (stall),
        .readIndex  (readIndex),
        .writeEnable(storeEnable),
        .writeIndex (storeIndex),
        .writeData  (storeData),
        .readData   (memReadData)
    );

    ioRegisterFile ioRegs (
        .clk        (clk),
        .reset      (reset),
        .readIndex  (ioReadIndex),
        .writeEnable(ioWriteEnable),
        .writeIndex (ioReadIndex),
        .writeData  (storeData[`IO_LANE]),
        .readData   (ioReadData)
    );

    memoryAccessStage memAccess (
        .clk          (clk),
        .reset        (reset),
        .stall        (stall),
        .clear        (clear),
        .phase        (phase),
        .flushAll     (flushAll),
        .flushHead    (flushHead),
        .flushTail    (flushTail),
        .tagValid     (tagValid),
        .tagKind      (tagKind),
        .tagOperand   (tagOperand),
        .tagMapType   (tagMapType),
        .tagStoreData (tagStoreData),
        .tagAlPtr     (tagAlPtr),
        .tagDst       (tagDst),
        .memReadData  (memReadData),
        .ioReadData   (ioReadData),
        .ioReadIndex  (ioReadIndex),
        .storeEnable  (storeEnable),
        .storeIndex   (storeIndex),
        .storeData    (storeData),
        .ioWriteEnable(ioWriteEnable),
        .bypassValid  (bypassValid),
        .bypassData   (bypassData),
        .nextValid    (nextValid),
        .nextData     (nextData),
        .nextDst      (nextDst),
        .nextAlPtr    (nextAlPtr)
    );

    // Writeback register takes bubbles while stalled
    always_ff @(posedge clk) begin
        if (reset) begin
            wbValid <= '0;
        end else begin
            wbValid <= nextValid;
        end
    end

    always_ff @(posedge clk) begin
        wbData  <= nextData;
        wbDst   <= nextDst;
        wbAlPtr <= nextAlPtr;
    end

endmodule

// File: rtl/memPipe_defines.svh
/*
 * Memory pipeline configuration
 * Lane count, data and pointer widths, memory depths
 */
`ifndef MEM_PIPE_DEFINES_SVH
`define MEM_PIPE_DEFINES_SVH

`define MEM_LANES 2
`define IO_LANE 0
`define DATA_WIDTH 32
`define DST_WIDTH 6

`define MEM_WORDS 256
`define MEM_INDEX_WIDTH ($clog2(`MEM_WORDS))
`define AL_ENTRIES 32
`define AL_PTR_WIDTH ($clog2(`AL_ENTRIES))

// Address region 0xF is memory-mapped IO
`define IO_REGION 4'hF
`define IO_REGS 8
`define IO_INDEX_WIDTH ($clog2(`IO_REGS))
`endif

// File: rtl/memoryAccessStage.sv
/*
 * Memory access stage
 * Holds the stage register, selects each lane's result, kills ops by
 * active-list range, commits stores and feeds the writeback register
 */
`include "memPipe_defines.svh"

module memoryAccessStage (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic                                         stall,
    input  logic                                         clear,
    input  recoveryPkg::recoveryPhase                    phase,
    input  logic                                         flushAll,
    input  recoveryPkg::activeListPtr                    flushHead,
    input  recoveryPkg::activeListPtr                    flushTail,
    input  logic [`MEM_LANES-1:0]                        tagValid,
    input  memOpPkg::opKind [`MEM_LANES-1:0]             tagKind,
    input  memOpPkg::operandWord [`MEM_LANES-1:0]        tagOperand,
    input  memOpPkg::memMapType [`MEM_LANES-1:0]         tagMapType,
    input  logic [`MEM_LANES-1:0][`DATA_WIDTH-1:0]       tagStoreData,
    input  recoveryPkg::activeListPtr [`MEM_LANES-1:0]   tagAlPtr,
    input  logic [`MEM_LANES-1:0][`DST_WIDTH-1:0]        tagDst,
    input  logic [`MEM_LANES-1:0][`DATA_WIDTH-1:0]       memReadData,
    input  logic [`DATA_WIDTH-1:0]                       ioReadData,
    output logic [`IO_INDEX_WIDTH-1:0]                   ioReadIndex,
    output logic [`MEM_LANES-1:0]                        storeEnable,
    output logic [`MEM_LANES-1:0][`MEM_INDEX_WIDTH-1:0]  storeIndex,
    output logic [`MEM_LANES-1:0][`DATA_WIDTH-1:0]       storeData,
    output logic                                         ioWriteEnable,
    output logic [`MEM_LANES-1:0]                        bypassValid,
    output logic [`MEM_LANES-1:0][`DATA_WIDTH-1:0]       bypassData,
    output logic [`MEM_LANES-1:0]                        nextValid,
    output logic [`MEM_LANES-1:0][`DATA_WIDTH-1:0]       nextData,
    output logic [`MEM_LANES-1:0][`DST_WIDTH-1:0]        nextDst,
    output recoveryPkg::activeListPtr [`MEM_LANES-1:0]   nextAlPtr
);

    logic [`MEM_LANES-1:0]                       regValid;
    memOpPkg::opKind [`MEM_LANES-1:0]            regKind;
    memOpPkg::operandWord [`MEM_LANES-1:0]       regOperand;
    memOpPkg::memMapType [`MEM_LANES-1:0]        regMapType;
    logic [`MEM_LANES-1:0][`DATA_WIDTH-1:0]      regStoreData;
    recoveryPkg::activeListPtr [`MEM_LANES-1:0]  regAlPtr;
    logic [`MEM_LANES-1:0][`DST_WIDTH-1:0]       regDst;

    logic [`MEM_LANES-1:0]                       flushed;
    logic [`MEM_LANES-1:0]                       update;
    logic [`MEM_LANES-1:0][`DATA_WIDTH-1:0]      result;

    always_ff @(posedge clk) begin
        if (reset) begin
            regValid <= '0;
        end else if (!stall) begin
            regValid <= tagValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            regKind      <= tagKind;
            regOperand   <= tagOperand;
            regMapType   <= tagMapType;
            regStoreData <= tagStoreData;
            regAlPtr     <= tagAlPtr;
            regDst       <= tagDst;
        end
    end

    for (genvar lane = 0; lane < `MEM_LANES; lane++) begin : genFlush
        flushRangeCheck flushCheck (
            .phase    (phase),
            .flushAll (flushAll),
            .flushHead(flushHead),
            .flushTail(flushTail),
            .opPtr    (regAlPtr[lane]),
            .flushed  (flushed[lane])
        );
    end

    always_comb begin
        for (int i = 0; i < `MEM_LANES; i++) begin
            update[i] = regValid[i] && !stall && !clear && !flushed[i];

            // Only the IO lane can see IO register data
            case (regKind[i])
                memOpPkg::OP_LOAD: begin
                    if (i == `IO_LANE && regMapType[i] == memOpPkg::MMT_IO) begin
                        result[i] = ioReadData;
                    end else begin
                        result[i] = memReadData[i];
                    end
                end
                memOpPkg::OP_CSR:   result[i] = regOperand[i].csrValue;
                memOpPkg::OP_STORE: result[i] = '0;
                default:            result[i] = regOperand[i].addr;
            endcase

            storeEnable[i] = update[i] && regKind[i] == memOpPkg::OP_STORE &&
                             regMapType[i] == memOpPkg::MMT_MEMORY;
            storeIndex[i]  = regOperand[i].addr.index[`MEM_INDEX_WIDTH-1:0];
            storeData[i]   = regStoreData[i];

            // Stores have no destination to bypass
            bypassValid[i] = regValid[i] && !flushed[i] && regKind[i] != memOpPkg::OP_STORE;
            bypassData[i]  = result[i];

            nextValid[i] = (stall || clear || reset || flushed[i]) ? 1'b0 : regValid[i];
            nextData[i]  = result[i];
            nextDst[i]   = regDst[i];
            nextAlPtr[i] = regAlPtr[i];
        end
    end

    assign ioReadIndex   = regOperand[`IO_LANE].addr.index[`IO_INDEX_WIDTH-1:0];
    assign ioWriteEnable = update[`IO_LANE] && regKind[`IO_LANE] == memOpPkg::OP_STORE &&
                           regMapType[`IO_LANE] == memOpPkg::MMT_IO;

endmodule

// File: rtl/recoveryPkg.sv
/*
 * Recovery types
 * Active-list pointer and the recovery phase seen by the flush logic
 */
`include "memPipe_defines.svh"

package recoveryPkg;

    // Index into the active list that wraps at AL_ENTRIES
    typedef logic [`AL_PTR_WIDTH-1:0] activeListPtr;

    typedef enum logic {
        RP_NONE  = 1'b0,
        RP_FLUSH = 1'b1
    } recoveryPhase;

endpackage

// File: verification/memPipeTb.sv
/*
 * Memory pipeline testbench
 * Runs latency, result, IO, flush and stall tests on the DUT
 */
`include "memPipe_defines.svh"

module memPipeTb;

    localparam int WAIT_LIMIT = 16;

    logic clk;
    logic reset;
    logic [`MEM_LANES-1:0]                       issueValid;
    memOpPkg::opKind [`MEM_LANES-1:0]            issueKind;
    memOpPkg::operandWord [`MEM_LANES-1:0]       issueOperand;
    logic [`MEM_LANES-1:0][`DATA_WIDTH-1:0]      issueStoreData;
    recoveryPkg::activeListPtr [`MEM_LANES-1:0]  issueAlPtr;
    logic [`MEM_LANES-1:0][`DST_WIDTH-1:0]       issueDst;
    recoveryPkg::recoveryPhase                   phase;
    logic                                        flushAll;
    recoveryPkg::activeListPtr                   flushHead;
    recoveryPkg::activeListPtr                   flushTail;
    logic                                        stall;
    logic                                        clear;
    logic [`MEM_LANES-1:0]                       bypassValid;
    logic [`MEM_LANES-1:0][`DATA_WIDTH-1:0]      bypassData;
    logic [`MEM_LANES-1:0]                       wbValid;
    logic [`MEM_LANES-1:0][`DATA_WIDTH-1:0]      wbData;
    logic [`MEM_LANES-1:0][`DST_WIDTH-1:0]       wbDst;
    recoveryPkg::activeListPtr [`MEM_LANES-1:0]  wbAlPtr;

    int errors = 0;
    int testsRun = 0;
    int testsFailed = 0;
    int errStart;
    int lat0;
    int lat1;
    logic [31:0] res0;
    logic [31:0] res1;
    logic [31:0] wordA;
    logic [31:0] wordB;

    tbClock clkGen (.clk(clk));

    memPipeTop UUT (.*);

    bind memPipeTop memPipeSva sva (
        .clk(clk), .reset(reset), .issueValid(issueValid), .issueKind(issueKind),
        .issueOperand(issueOperand), .phase(phase), .flushAll(flushAll), .stall(stall),
        .clear(clear), .tagValid(tagValid), .tagMapType(tagMapType),
        .storeEnable(storeEnable), .ioWriteEnable(ioWriteEnable),
        .bypassValid(bypassValid), .wbValid(wbValid), .wbData(wbData)
    );

    function automatic logic [31:0] memWord(input int idx);
        return {4'h0, 26'(idx), 2'b00};
    endfunction

    function automatic logic [31:0] ioWord(input int idx);
        return {4'hF, 26'(idx), 2'b00};
    endfunction

    // Check errors plus assertion failures so far
    function automatic int failureCount();
        return errors + UUT.sva.failCount;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("error: %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // Issues one op and waits for its writeback with latency -1 if none comes
    task automatic runOp(input int lane, input memOpPkg::opKind kind, input logic [31:0] operand,
                         input logic [31:0] sdata, input logic [4:0] ptr, input logic [5:0] dst,
                         output int latency, output logic [31:0] data);
        int cycles;
        @(posedge clk);
        issueValid[lane]     <= 1'b1;
        issueKind[lane]      <= kind;
        issueOperand[lane]   <= operand;
        issueStoreData[lane] <= sdata;
        issueAlPtr[lane]     <= ptr;
        issueDst[lane]       <= dst;
        @(posedge clk);
        issueValid[lane] <= 1'b0;
        cycles = 1;
        latency = -1;
        data = '0;
        while (latency < 0 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            if (wbValid[lane]) begin
                latency = cycles;
                data = wbData[lane];
                checkValue("wbDst", 32'(wbDst[lane]), 32'(dst));
                checkValue("wbAlPtr", 32'(wbAlPtr[lane]), 32'(ptr));
            end else begin
                cycles++;
            end
        end
    endtask

    task automatic expectDone(input string name, input int latency, input int expLatency,
                              input logic [31:0] got, input logic [31:0] exp);
        if (latency < 0) begin
            $display("timeout waiting for writeback of %s", name);
            errors++;
        end else begin
            checkValue({name, " latency"}, 32'(latency), 32'(expLatency));
            checkValue({name, " wbData"}, got, exp);
        end
    endtask

    task automatic expectKilled(input string name, input int latency);
        if (latency >= 0) begin
            $display("%s reached writeback although it was removed", name);
            errors++;
        end
    endtask

    // Raises stall (0), clear (1) or the flush phase (2) for len cycles
    task automatic pulse(input int delay, input int len, input int which);
        repeat (delay) @(posedge clk);
        case (which)
            0: stall <= 1'b1;
            1: clear <= 1'b1;
            default: phase <= recoveryPkg::RP_FLUSH;
        endcase
        repeat (len) @(posedge clk);
        stall <= 1'b0;
        clear <= 1'b0;
        phase <= recoveryPkg::RP_NONE;
    endtask

    task automatic watchBypass(input int k, input logic [31:0] exp);
        repeat (3) @(posedge clk);
        repeat (k) begin
            @(negedge clk);
            checkValue("bypassValid", 32'(bypassValid[0]), 32'd1);
            checkValue("bypassData", bypassData[0], exp);
        end
    endtask

    task automatic finishTest(input string name);
        int count;
        count = failureCount();
        testsRun++;
        if (count != errStart) testsFailed++;
        $display("test %0d %s: %s", testsRun, name, (count == errStart) ? "ok" : "failed");
        errStart = count;
    endtask

    initial begin
        repeat (4000) @(posedge clk);
        $display("timeout: simulation did not finish");
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(93));
        reset = 1'b1;
        issueValid = '0;
        issueKind = '0;
        issueOperand = '0;
        issueStoreData = '0;
        issueAlPtr = '0;
        issueDst = '0;
        phase = recoveryPkg::RP_NONE;
        flushAll = 1'b0;
        flushHead = '0;
        flushTail = '0;
        stall = 1'b0;
        clear = 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        errStart = failureCount();

        @(negedge clk);
        checkValue("wbValid", 32'(wbValid), 32'd0);
        checkValue("bypassValid", 32'(bypassValid), 32'd0);
        runOp(0, memOpPkg::OP_ADDR, memWord(3), '0, 5'd9, 6'd33, lat0, res0);
        expectDone("address op", lat0, 3, res0, memWord(3));
        finishTest("latency and reset");

        wordA = $urandom;
        wordB = $urandom;
        runOp(0, memOpPkg::OP_STORE, memWord(10), wordA, 5'd1, 6'd1, lat0, res0);
        expectDone("store lane 0", lat0, 3, res0, '0);
        runOp(1, memOpPkg::OP_STORE, memWord(11), wordB, 5'd2, 6'd2, lat1, res1);
        expectDone("store lane 1", lat1, 3, res1, '0);
        runOp(0, memOpPkg::OP_LOAD, memWord(11), '0, 5'd3, 6'd3, lat0, res0);
        expectDone("load lane 0", lat0, 3, res0, wordB);
        runOp(1, memOpPkg::OP_LOAD, memWord(10), '0, 5'd4, 6'd4, lat1, res1);
        expectDone("load lane 1", lat1, 3, res1, wordA);
        runOp(1, memOpPkg::OP_CSR, 32'hF00D_CAFE, '0, 5'd5, 6'd5, lat1, res1);
        expectDone("CSR op", lat1, 3, res1, 32'hF00D_CAFE);
        runOp(1, memOpPkg::OP_ADDR, 32'h1234_5678, '0, 5'd6, 6'd6, lat1, res1);
        expectDone("address op", lat1, 3, res1, 32'h1234_5678);
        finishTest("result selection");

        runOp(0, memOpPkg::OP_LOAD, ioWord(5), '0, 5'd7, 6'd7, lat0, res0);
        expectDone("IO load", lat0, 3, res0, 32'h55);
        wordA = $urandom;
        runOp(0, memOpPkg::OP_STORE, ioWord(3), wordA, 5'd8, 6'd8, lat0, res0);
        expectDone("IO store", lat0, 3, res0, '0);
        runOp(0, memOpPkg::OP_LOAD, ioWord(3), '0, 5'd9, 6'd9, lat0, res0);
        expectDone("IO reload", lat0, 3, res0, wordA);
        finishTest("IO path");

        wordA = $urandom;
        wordB = $urandom;
        runOp(0, memOpPkg::OP_STORE, memWord(20), wordA, 5'd10, 6'd10, lat0, res0);
        expectDone("store before flush", lat0, 3, res0, '0);
        @(posedge clk);
        flushHead <= 5'd5;
        flushTail <= 5'd9;
        fork
            runOp(1, memOpPkg::OP_STORE, memWord(20), wordB, 5'd7, 6'd11, lat1, res1);
            pulse(3, 1, 2);
        join
        expectKilled("store in flush range", lat1);
        runOp(1, memOpPkg::OP_LOAD, memWord(20), '0, 5'd12, 6'd12, lat1, res1);
        expectDone("load after killed store", lat1, 3, res1, wordA);
        fork
            runOp(0, memOpPkg::OP_ADDR, memWord(1), '0, 5'd12, 6'd13, lat0, res0);
            pulse(3, 1, 2);
        join
        expectDone("op outside range", lat0, 3, res0, memWord(1));
        @(posedge clk);
        flushHead <= 5'd30;
        flushTail <= 5'd2;
        fork
            runOp(0, memOpPkg::OP_ADDR, memWord(2), '0, 5'd0, 6'd14, lat0, res0);
            pulse(3, 1, 2);
        join
        expectKilled("op in wrapped range", lat0);
        @(posedge clk);
        flushAll <= 1'b1;
        fork
            runOp(0, memOpPkg::OP_STORE, memWord(20), ~wordA, 5'd15, 6'd15, lat0, res0);
            runOp(1, memOpPkg::OP_STORE, memWord(20), ~wordA, 5'd16, 6'd16, lat1, res1);
            pulse(3, 1, 2);
        join
        @(posedge clk);
        flushAll <= 1'b0;
        expectKilled("lane 0 under flushAll", lat0);
        expectKilled("lane 1 under flushAll", lat1);
        runOp(0, memOpPkg::OP_LOAD, memWord(20), '0, 5'd20, 6'd20, lat0, res0);
        expectDone("load after full flush", lat0, 3, res0, wordA);
        finishTest("selective flush");

        fork
            runOp(0, memOpPkg::OP_CSR, 32'hABCD_0123, '0, 5'd17, 6'd17, lat0, res0);
            runOp(1, memOpPkg::OP_STORE, memWord(24), wordB, 5'd19, 6'd19, lat1, res1);
            pulse(3, 3, 0);
            watchBypass(3, 32'hABCD_0123);
        join
        expectDone("stalled op", lat0, 6, res0, 32'hABCD_0123);
        expectDone("stalled store", lat1, 6, res1, '0);
        runOp(1, memOpPkg::OP_LOAD, memWord(24), '0, 5'd21, 6'd21, lat1, res1);
        expectDone("load after stalled store", lat1, 3, res1, wordB);
        fork
            runOp(1, memOpPkg::OP_ADDR, memWord(4), '0, 5'd18, 6'd18, lat1, res1);
            pulse(3, 1, 1);
        join
        expectKilled("cleared op", lat1);
        finishTest("stall and clear");

        $display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
                 testsRun, testsFailed, errors, UUT.sva.failCount);
        if (errors == 0 && UUT.sva.failCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: verification/memPipe_sva.sv
/*
 * Concurrent checks for the memory pipeline slice
 * Latency, result selection, IO lane use, flush and stall behavior
 */
`include "memPipe_defines.svh"

module memPipeSva (
    input logic                                   clk,
    input logic                                   reset,
    input logic [`MEM_LANES-1:0]                  issueValid,
    input logic [`MEM_LANES-1:0][1:0]             issueKind,
    input logic [`MEM_LANES-1:0][`DATA_WIDTH-1:0] issueOperand,
    input logic                                   phase,
    input logic                                   flushAll,
    input logic                                   stall,
    input logic                                   clear,
    input logic [`MEM_LANES-1:0]                  tagValid,
    input logic [`MEM_LANES-1:0]                  tagMapType,
    input logic [`MEM_LANES-1:0]                  storeEnable,
    input logic                                   ioWriteEnable,
    input logic [`MEM_LANES-1:0]                  bypassValid,
    input logic [`MEM_LANES-1:0]                  wbValid,
    input logic [`MEM_LANES-1:0][`DATA_WIDTH-1:0] wbData
);

    int failCount = 0;

    // Nothing valid leaves reset
    assert property (@(posedge clk) reset |=> wbValid == '0 && bypassValid == '0)
        else begin failCount++; $error("valid output after reset"); end

    for (genvar l = 0; l < `MEM_LANES; l++) begin : genLane
        // Undisturbed op reaches writeback on the third edge
        assert property (@(posedge clk) disable iff (reset)
            issueValid[l] && !stall ##1 !stall ##1
            (!stall && !clear && phase == recoveryPkg::RP_NONE) |=> wbValid[l])
            else begin failCount++; $error("lane %0d missed 3-cycle writeback", l); end

        // Stores give zero and other non-load ops their operand word
        assert property (@(posedge clk) disable iff (reset)
            issueValid[l] && issueKind[l] != memOpPkg::OP_LOAD && !stall ##1 !stall ##1
            (!stall && !clear && phase == recoveryPkg::RP_NONE) |=>
            wbData[l] == (($past(issueKind[l], 3) == memOpPkg::OP_STORE) ?
                          '0 : $past(issueOperand[l], 3)))
            else begin failCount++; $error("lane %0d wrong non-load result", l); end
    end

    assert property (@(posedge clk) disable iff (reset)
        !(tagValid[1] && tagMapType[1] == memOpPkg::MMT_IO))
        else begin failCount++; $error("IO access on lane 1"); end

    assert property (@(posedge clk) disable iff (reset)
        phase == recoveryPkg::RP_FLUSH && flushAll |-> storeEnable == '0 && !ioWriteEnable)
        else begin failCount++; $error("store during full flush"); end

    assert property (@(posedge clk) disable iff (reset)
        phase == recoveryPkg::RP_FLUSH && flushAll |=> wbValid == '0)
        else begin failCount++; $error("writeback after full flush"); end

    assert property (@(posedge clk) disable iff (reset)
        stall |-> storeEnable == '0 && !ioWriteEnable)
        else begin failCount++; $error("store while stalled"); end

    assert property (@(posedge clk) disable iff (reset) stall || clear |=> wbValid == '0)
        else begin failCount++; $error("writeback after stall or clear"); end

    // Stalled stage keeps showing its ops
    assert property (@(posedge clk) disable iff (reset)
        stall && phase == recoveryPkg::RP_NONE |=> bypassValid == $past(bypassValid))
        else begin failCount++; $error("bypass changed under stall"); end

endmodule

// File: verification/tbClock.sv
/*
 * Testbench clock source
 * Free-running clock with a period of 4 time units
 */
module tbClock (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;

endmodule
